/* dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

	// address and line geometry, tied to the 16-bit word address
	localparam int ADDR_W         = 16;
	localparam int WORD_W         = 16;
	localparam int WORDS_PER_LINE = 4;
	localparam int OFFSET_W       = 2;
	localparam int LINE_W         = 64;
	localparam int SETS           = 32;
	localparam int INDEX_W        = 5;
	localparam int TAG_W          = 9;   // addr[15:7]
	localparam int LINE_ADDR_W    = 14;  // addr[15:2]

	typedef enum logic {
		op_read,
		op_write
	} req_op_e;

	typedef struct packed {
		req_op_e           op;
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] wdata;
	} cpu_req_t;

	typedef struct packed {
		logic                   we;
		logic [LINE_ADDR_W-1:0] line_addr;
		logic [LINE_W-1:0]      wdata;
	} mem_req_t;

	// one stored entry of a way
	typedef struct packed {
		logic              valid;
		logic              dirty;
		logic [TAG_W-1:0]  tag;
		logic [LINE_W-1:0] data;
	} line_t;

	typedef enum logic [2:0] {
		st_idle,
		st_lookup,
		st_writeback,
		st_fill,
		st_respond
	} ctrl_state_e;

endpackage

`default_nettype wire

/* dcache_ways.sv */
`default_nettype none

module dcache_ways import dcache_pkg::*; (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic [ADDR_W-1:0] i_addr,
	output logic                   o_hit,
	output logic                   o_hit_way,
	output logic                   o_victim_way,
	output line_t                  o_victim_line,
	output logic [WORD_W-1:0]      o_rd_word,
	input  wire logic [1:0]        i_way_we,
	input  wire line_t             i_wr_line,
	input  wire logic              i_merge_wr,
	input  wire logic [WORD_W-1:0] i_wdata,
	input  wire logic              i_lru_we,
	input  wire logic              i_lru_way
);
	line_t               ways_q [2][SETS];
	logic [SETS-1:0]     lru_q;  // way used last in each set
	logic [INDEX_W-1:0]  idx;
	logic [TAG_W-1:0]    tag;
	logic [OFFSET_W-1:0] off;
	line_t               rd_line [2];
	line_t               wr_line [2];
	logic [1:0]          hit_vec;

	assign idx = i_addr[OFFSET_W +: INDEX_W];
	assign tag = i_addr[ADDR_W-1 -: TAG_W];
	assign off = i_addr[OFFSET_W-1:0];

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			rd_line[w] = ways_q[w][idx];
			hit_vec[w] = rd_line[w].valid && (rd_line[w].tag == tag);
		end
	end

	assign o_hit = |hit_vec;
	assign o_hit_way = ~hit_vec[0];
	assign o_rd_word = rd_line[o_hit_way].data[off*WORD_W +: WORD_W];

	// empty way 0, then empty way 1, else the way not used last
	always_comb begin
		if (!rd_line[0].valid)
			o_victim_way = 1'b0;
		else if (!rd_line[1].valid)
			o_victim_way = 1'b1;
		else
			o_victim_way = ~lru_q[idx];
	end

	assign o_victim_line = rd_line[o_victim_way];

	// store merge, on a hit the word goes into the stored line, on a fill into the new one
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			wr_line[w] = i_wr_line;
			if (i_merge_wr) begin
				if (hit_vec[w])
					wr_line[w].data = rd_line[w].data;
				wr_line[w].data[off*WORD_W +: WORD_W] = i_wdata;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < 2; w++) begin
			if (rst) begin
				for (int s = 0; s < SETS; s++) begin
					ways_q[w][s].valid <= 1'b0;
					ways_q[w][s].dirty <= 1'b0;
				end
			end else if (i_way_we[w]) begin
				ways_q[w][idx] <= wr_line[w];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			lru_q <= '0;
		else if (i_lru_we)
			lru_q[idx] <= i_lru_way;
	end

endmodule

`default_nettype wire

/* dcache_ctrl.sv */
`default_nettype none

module dcache_ctrl import dcache_pkg::*; (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              i_req_valid,
	output logic                   o_req_ready,
	input  wire cpu_req_t          i_req,
	output logic                   o_rsp_valid,
	output logic [WORD_W-1:0]      o_rsp_data,
	output logic [ADDR_W-1:0]      o_addr,
	output logic [WORD_W-1:0]      o_wdata,
	input  wire logic              i_hit,
	input  wire logic              i_hit_way,
	input  wire logic              i_victim_way,
	input  wire line_t             i_victim_line,
	input  wire logic [WORD_W-1:0] i_rd_word,
	output logic [1:0]             o_way_we,
	output line_t                  o_wr_line,
	output logic                   o_merge_wr,
	output logic                   o_lru_we,
	output logic                   o_lru_way,
	output logic                   o_mem_req_valid,
	input  wire logic              i_mem_req_ready,
	output mem_req_t               o_mem_req,
	input  wire logic              i_mem_rsp_valid,
	input  wire logic [LINE_W-1:0] i_mem_rsp_data
);
	ctrl_state_e        state_q;
	ctrl_state_e        state_d;
	cpu_req_t           req_q;       // request being served
	logic               mem_busy_q;  // memory took our request, response pending
	logic               is_write;
	logic [INDEX_W-1:0] idx;

	assign is_write = (req_q.op == op_write);
	assign idx = req_q.addr[OFFSET_W +: INDEX_W];

	assign o_addr = req_q.addr;
	assign o_wdata = req_q.wdata;
	assign o_req_ready = (state_q == st_idle);  // one request at a time
	assign o_rsp_data = i_rd_word;              // hit line, or the line just filled

	// only one memory access per wait, valid drops once accepted
	assign o_mem_req_valid = (state_q == st_writeback || state_q == st_fill) && !mem_busy_q;

	always_comb begin
		o_mem_req.we = (state_q == st_writeback);
		o_mem_req.wdata = i_victim_line.data;
		if (state_q == st_writeback)
			o_mem_req.line_addr = {i_victim_line.tag, idx};  // victim's home line
		else
			o_mem_req.line_addr = req_q.addr[ADDR_W-1:OFFSET_W];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= st_idle;
			mem_busy_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (o_mem_req_valid && i_mem_req_ready)
				mem_busy_q <= 1'b1;
			else if (i_mem_rsp_valid)
				mem_busy_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (o_req_ready && i_req_valid)
			req_q <= i_req;
	end

	always_comb begin
		state_d = state_q;
		o_rsp_valid = 1'b0;
		o_way_we = 2'b00;
		o_lru_we = 1'b0;
		o_lru_way = i_victim_way;
		o_merge_wr = is_write;
		// fill line, a store hit keeps the stored words and only takes the flags
		o_wr_line.valid = 1'b1;
		o_wr_line.dirty = is_write;
		o_wr_line.tag = req_q.addr[ADDR_W-1 -: TAG_W];
		o_wr_line.data = i_mem_rsp_data;

		case (state_q)
			st_idle: begin
				if (i_req_valid)
					state_d = st_lookup;
			end
			st_lookup: begin
				if (i_hit) begin
					o_rsp_valid = 1'b1;
					o_lru_we = 1'b1;
					o_lru_way = i_hit_way;
					o_way_we[i_hit_way] = is_write;
					state_d = st_idle;
				end else if (i_victim_line.valid && i_victim_line.dirty) begin
					state_d = st_writeback;
				end else begin
					state_d = st_fill;
				end
			end
			st_writeback: begin
				if (i_mem_rsp_valid)  // write acknowledged
					state_d = st_fill;
			end
			st_fill: begin
				if (i_mem_rsp_valid) begin
					o_way_we[i_victim_way] = 1'b1;
					o_lru_we = 1'b1;
					state_d = st_respond;
				end
			end
			st_respond: begin
				o_rsp_valid = 1'b1;  // line now hits, word comes from the ways
				state_d = st_idle;
			end
			default: state_d = st_idle;
		endcase
	end

endmodule

`default_nettype wire

/* main_mem.sv */
`default_nettype none

module main_mem import dcache_pkg::*; #(
	parameter int MEM_LATENCY = 3
) (
	input  wire logic          clk,
	input  wire logic          rst,
	input  wire logic          i_req_valid,
	output logic               o_req_ready,
	input  wire mem_req_t      i_req,
	output logic               o_rsp_valid,
	output logic [LINE_W-1:0]  o_rsp_data
);
	localparam int CNT_W = $clog2(MEM_LATENCY + 1);

	typedef enum logic {
		mem_wait,
		mem_count
	} mem_state_e;

	logic [LINE_W-1:0] mem [2**LINE_ADDR_W];
	mem_state_e        state_q;
	mem_state_e        state_d;
	logic [CNT_W-1:0]  cnt_q;  // cycles left in the current access
	logic              accept;

	// every word holds its own word address
	initial begin
		for (int l = 0; l < 2**LINE_ADDR_W; l++) begin
			for (int k = 0; k < WORDS_PER_LINE; k++)
				mem[l][k*WORD_W +: WORD_W] = WORD_W'(l * WORDS_PER_LINE + k);
		end
	end

	assign o_req_ready = (state_q == mem_wait);
	assign accept = i_req_valid && o_req_ready;
	assign o_rsp_valid = (state_q == mem_count) && (cnt_q == '0);

	always_comb begin
		state_d = state_q;
		case (state_q)
			mem_wait: begin
				if (accept)
					state_d = mem_count;
			end
			mem_count: begin
				if (cnt_q == '0)
					state_d = mem_wait;
			end
			default: state_d = mem_wait;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= mem_wait;
			cnt_q <= '0;
		end else begin
			state_q <= state_d;
			if (accept)
				cnt_q <= CNT_W'(MEM_LATENCY - 1);
			else if (cnt_q != '0)
				cnt_q <= cnt_q - 1'b1;
		end
	end

	// read data captured at acceptance, writes land right away
	always @(posedge clk) begin
		if (accept) begin
			o_rsp_data <= mem[i_req.line_addr];
			if (i_req.we)
				mem[i_req.line_addr] <= i_req.wdata;
		end
	end

endmodule

`default_nettype wire

/* dcache_top.sv */
`default_nettype none

module dcache_top import dcache_pkg::*; #(
	parameter int MEM_LATENCY = 3
) (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic               i_req_valid,
	output logic                    o_req_ready,
	input  wire cpu_req_t           i_req,
	output logic                    o_rsp_valid,
	output logic [WORD_W-1:0]       o_rsp_data
);
	logic [ADDR_W-1:0] addr;
	logic [WORD_W-1:0] wdata;
	logic              hit;
	logic              hit_way;
	logic              victim_way;
	line_t             victim_line;
	logic [WORD_W-1:0] rd_word;
	logic [1:0]        way_we;
	line_t             wr_line;
	logic              merge_wr;
	logic              lru_we;
	logic              lru_way;

	logic              mem_req_valid;
	logic              mem_req_ready;
	mem_req_t          mem_req;
	logic              mem_rsp_valid;
	logic [LINE_W-1:0] mem_rsp_data;

	dcache_ctrl u_ctrl (
		.clk, .rst,
		.i_req_valid, .o_req_ready, .i_req,
		.o_rsp_valid, .o_rsp_data,
		.o_addr(addr), .o_wdata(wdata),
		.i_hit(hit), .i_hit_way(hit_way),
		.i_victim_way(victim_way), .i_victim_line(victim_line),
		.i_rd_word(rd_word),
		.o_way_we(way_we), .o_wr_line(wr_line), .o_merge_wr(merge_wr),
		.o_lru_we(lru_we), .o_lru_way(lru_way),
		.o_mem_req_valid(mem_req_valid), .i_mem_req_ready(mem_req_ready),
		.o_mem_req(mem_req),
		.i_mem_rsp_valid(mem_rsp_valid), .i_mem_rsp_data(mem_rsp_data)
	);

	dcache_ways u_ways (
		.clk, .rst,
		.i_addr(addr),
		.o_hit(hit), .o_hit_way(hit_way),
		.o_victim_way(victim_way), .o_victim_line(victim_line),
		.o_rd_word(rd_word),
		.i_way_we(way_we), .i_wr_line(wr_line),
		.i_merge_wr(merge_wr), .i_wdata(wdata),
		.i_lru_we(lru_we), .i_lru_way(lru_way)
	);

	main_mem #(.MEM_LATENCY(MEM_LATENCY)) u_mem (
		.clk, .rst,
		.i_req_valid(mem_req_valid), .o_req_ready(mem_req_ready),
		.i_req(mem_req),
		.o_rsp_valid(mem_rsp_valid), .o_rsp_data(mem_rsp_data)
	);

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
	output logic o_clk,
	output logic o_rst
);
	initial begin
		o_clk = 1'b0;
		forever #10 o_clk = ~o_clk;  // period 20
	end

	// synchronous reset, held over the first 4 rising edges
	initial begin
		o_rst = 1'b1;
		repeat (4) @(posedge o_clk);
		o_rst <= 1'b0;
	end

endmodule

`default_nettype wire

/* tb_checker.sv */
`default_nettype none

module tb_checker import dcache_pkg::*; (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              i_req_valid,
	input  wire logic              i_req_ready,
	input  wire cpu_req_t          i_req,
	input  wire logic              i_rsp_valid,
	input  wire logic [WORD_W-1:0] i_rsp_data,
	output int                     o_errors,
	output int                     o_responses
);
	logic [WORD_W-1:0] shadow [2**ADDR_W];  // word memory as the CPU sees it
	string             names_q [$];
	logic              hits_q [$];
	string             cur_name;
	logic              cur_hit;         // answer due one cycle after acceptance
	cpu_req_t          cur_req;
	logic [WORD_W-1:0] cur_exp;
	logic              in_flight = 1'b0;
	int                cycle = 0;
	int                acc_cycle = 0;
	int                passes = 0;
	int                errors = 0;
	int                responses = 0;

	assign o_errors = errors;
	assign o_responses = responses;

	// preload pattern, each word holds its own address
	initial begin
		for (int a = 0; a < 2**ADDR_W; a++)
			shadow[a] = WORD_W'(a);
	end

	task automatic expect_entry(input string name, input logic exp_hit);
		names_q.push_back(name);
		hits_q.push_back(exp_hit);
	endtask

	task automatic print_summary();
		$display("summary: %0d passed, %0d errors, %0d responses", passes, errors, responses);
	endtask

	// DUT outputs are settled at the falling edge
	always @(negedge clk) begin
		logic ok;
		cycle++;
		if (!rst && i_rsp_valid) begin
			ok = 1'b1;
			responses++;
			if (!in_flight) begin
				$display("a response arrived with no request in flight");
				errors++;
			end else begin
				in_flight = 1'b0;
				if (cur_req.op == op_read && i_rsp_data !== cur_exp) begin
					$display("[FAIL] %s: expected %h, actual %h", cur_name, cur_exp, i_rsp_data);
					ok = 1'b0;
				end
				if (cur_hit && (cycle - acc_cycle) != 1) begin
					$display("[FAIL] %s: response delay expected 1, actual %0d",
						cur_name, cycle - acc_cycle);
					ok = 1'b0;
				end
				if (ok) begin
					$display("[PASS] %s", cur_name);
					passes++;
				end else begin
					errors++;
				end
			end
		end
		if (!rst && i_req_valid && i_req_ready) begin
			if (names_q.size() == 0) begin
				$display("a request was accepted with no table entry pending");
				errors++;
				cur_name = "unknown";
				cur_hit = 1'b0;
			end else begin
				cur_name = names_q.pop_front();
				cur_hit = hits_q.pop_front();
			end
			cur_req = i_req;
			acc_cycle = cycle;
			in_flight = 1'b1;
			if (i_req.op == op_write)
				shadow[i_req.addr] = i_req.wdata;
			cur_exp = shadow[i_req.addr];
		end
	end

endmodule

`default_nettype wire

/* tb_dcache_assertions.sv */
`default_nettype none

module tb_dcache_assertions import dcache_pkg::*; (
	input wire logic     clk,
	input wire logic     rst,
	input wire logic     i_req_valid,
	input wire logic     i_req_ready,
	input wire logic     i_rsp_valid,
	input wire logic     i_mem_req_valid,
	input wire logic     i_mem_req_ready,
	input wire mem_req_t i_mem_req
);
	int fail_count = 0;

	rsp_one_cycle: assert property (@(posedge clk) disable iff (rst)
		i_rsp_valid |=> !i_rsp_valid)
	else begin
		$error("response valid lasted two cycles");
		fail_count++;
	end

	// ready stays low from acceptance until the response cycle
	busy_no_ready: assert property (@(posedge clk) disable iff (rst)
		(i_req_valid && i_req_ready) || (!i_req_ready && !i_rsp_valid) |=> !i_req_ready)
	else begin
		$error("request ready rose before the response");
		fail_count++;
	end

	mem_req_stable: assert property (@(posedge clk) disable iff (rst)
		i_mem_req_valid && !i_mem_req_ready |=> i_mem_req_valid && $stable(i_mem_req))
	else begin
		$error("memory request changed while waiting for ready");
		fail_count++;
	end

endmodule

bind dcache_ctrl tb_dcache_assertions ctrl_assertions (
	.clk,
	.rst,
	.i_req_valid,
	.i_req_ready(o_req_ready),
	.i_rsp_valid(o_rsp_valid),
	.i_mem_req_valid(o_mem_req_valid),
	.i_mem_req_ready,
	.i_mem_req(o_mem_req)
);

`default_nettype wire

/* tb_dcache.sv */
`default_nettype none

module tb_dcache import dcache_pkg::*; ();
	localparam int MEM_LATENCY = 3;
	localparam int N_FIXED = 14;
	localparam int N_RANDOM = 12;
	localparam int N_TESTS = N_FIXED + N_RANDOM;
	localparam int TIMEOUT = N_TESTS * (2 * MEM_LATENCY + 8) * 20 + 4 * 20;

	typedef struct packed {
		req_op_e           op;
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] wdata;
		logic              exp_hit;  // must answer one cycle after acceptance
	} stim_t;

	logic              clk;
	logic              rst;
	logic              req_valid;
	logic              req_ready;
	cpu_req_t          req;
	logic              rsp_valid;
	logic [WORD_W-1:0] rsp_data;
	int                errors;
	int                responses;
	int                assert_fails;
	stim_t             stim_tab [N_TESTS];
	string             names [N_TESTS];
	logic [31:0]       lcg_state;

	tb_clock_gen u_clock (.o_clk(clk), .o_rst(rst));

	dcache_top #(.MEM_LATENCY(MEM_LATENCY)) dcache_top_inst (
		.clk, .rst,
		.i_req_valid(req_valid), .o_req_ready(req_ready), .i_req(req),
		.o_rsp_valid(rsp_valid), .o_rsp_data(rsp_data)
	);

	tb_checker u_checker (
		.clk, .rst,
		.i_req_valid(req_valid), .i_req_ready(req_ready), .i_req(req),
		.i_rsp_valid(rsp_valid), .i_rsp_data(rsp_data),
		.o_errors(errors), .o_responses(responses)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic set_entry(input int i, input string name, input req_op_e op,
			input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] wdata,
			input logic exp_hit);
		names[i] = name;
		stim_tab[i] = '{op: op, addr: addr, wdata: wdata, exp_hit: exp_hit};
	endtask

	// mixed ops over sets 0..3, four tags per set
	task automatic add_random_entries();
		logic [31:0] r;
		for (int i = 0; i < N_RANDOM; i++) begin
			lcg_state = lcg_next(lcg_state);
			r = lcg_state;
			lcg_state = lcg_next(lcg_state);
			set_entry(N_FIXED + i, $sformatf("rand_%0d", i), r[28] ? op_write : op_read,
				{7'b0011_000, r[17:16], 3'b000, r[19:18], r[21:20]},
				lcg_state[31:16], 1'b0);
		end
	endtask

	task automatic present(input int i);
		u_checker.expect_entry(names[i], stim_tab[i].exp_hit);
		req_valid <= 1'b1;
		req <= '{op: stim_tab[i].op, addr: stim_tab[i].addr, wdata: stim_tab[i].wdata};
	endtask

	initial begin
		#(TIMEOUT);
		$display("the run timed out after %0d time units without finishing", TIMEOUT);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		req_valid = 1'b0;
		req = '0;
		lcg_state = 32'h6f63_1e26;
		set_entry(0, "first_read", op_read, 16'h0123, 16'h0000, 1'b0);
		set_entry(1, "write_word", op_write, 16'h0200, 16'hbeef, 1'b0);
		set_entry(2, "read_written", op_read, 16'h0200, 16'h0000, 1'b1);
		set_entry(3, "neighbour_1", op_read, 16'h0201, 16'h0000, 1'b1);
		set_entry(4, "neighbour_3", op_read, 16'h0203, 16'h0000, 1'b1);
		set_entry(5, "evict_wr_a", op_write, 16'h0404, 16'h1111, 1'b0);
		set_entry(6, "evict_wr_b", op_write, 16'h0804, 16'h2222, 1'b0);
		set_entry(7, "evict_wr_c", op_write, 16'h0c04, 16'h3333, 1'b0);
		set_entry(8, "evict_rd_a", op_read, 16'h0404, 16'h0000, 1'b0);
		set_entry(9, "evict_rd_b", op_read, 16'h0804, 16'h0000, 1'b0);
		set_entry(10, "evict_rd_c", op_read, 16'h0c04, 16'h0000, 1'b0);
		set_entry(11, "fill_read", op_read, 16'h1a30, 16'h0000, 1'b0);
		set_entry(12, "hit_timing", op_read, 16'h1a30, 16'h0000, 1'b1);
		set_entry(13, "hit_timing_next", op_read, 16'h1a31, 16'h0000, 1'b1);
		add_random_entries();

		wait (!rst);
		@(posedge clk);
		present(0);
		for (int i = 0; i < N_TESTS; i++) begin
			do @(negedge clk); while (!req_ready);
			@(posedge clk);  // accept edge
			if (i + 1 < N_TESTS)
				present(i + 1);  // next request held valid while ready is low
			else
				req_valid <= 1'b0;
			do @(negedge clk); while (!rsp_valid);
		end
		repeat (3) @(posedge clk);  // room for a stray extra response

		assert_fails = dcache_top_inst.u_ctrl.ctrl_assertions.fail_count;
		if (responses != N_TESTS)
			$display("wrong number of responses: expected %0d, got %0d", N_TESTS, responses);
		u_checker.print_summary();
		if (errors == 0 && responses == N_TESTS && assert_fails == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* dcache.f */
dcache_pkg.sv
dcache_ways.sv
dcache_ctrl.sv
main_mem.sv
dcache_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_dcache_assertions.sv
tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - dcache_ways.sv
  - dcache_ctrl.sv
  - main_mem.sv
  - dcache_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_checker.sv
      - tb_dcache_assertions.sv
      - tb_dcache.sv
